/* Makefile */
TOOL       = verilator
TOP        = tb_sap_cpu
FILELIST   = project.f
FLAGS      = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
RUN_ARGS   = +verilator+error+limit+1000
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/alu.sv
rtl/program_ram.sv
rtl/control_sequencer.sv
rtl/cpu_datapath.sv
rtl/sap_cpu_top.sv
tests/sap_cpu_props.sv
tests/tb_sap_cpu.sv

/* tests/tb_sap_cpu.sv */
// Accumulator CPU testbench
`default_nettype none

module tb_sap_cpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_BYTES = 16;
    localparam int MAX_STEPS = 40;              // Instruction cap per run

    logic       clk;
    logic       arst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;                         // Bit 0 prog, bit 1 write strobe
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    isa_pkg::ram_word_u img [RAM_BYTES];        // Program image and model RAM
    logic [7:0] m_a;                            // Model accumulator
    logic [7:0] m_out = 8'h00;
    logic       m_carry = 1'b0;
    logic       m_zero = 1'b0;
    int         seed = 79;
    int         test_errors = 0;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         prop_fails;

    sap_cpu_top #(.RAM_BYTES(RAM_BYTES)) u_sap_cpu_top (
        .ui_in(ui_in), .uo_out(uo_out), .uio_in(uio_in), .uio_out(uio_out),
        .uio_oe(uio_oe), .ena(ena), .clk(clk), .arst_n(arst_n)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic isa_pkg::ram_word_u encode(input logic [3:0] opc, input logic [3:0] opd);
        isa_pkg::ram_word_u w;
        w.instr.opcode  = opc;
        w.instr.operand = opd;
        return w;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_byte(name, {7'd0, got}, {7'd0, exp});
    endtask

    task automatic fill_random();
        for (int i = 0; i < RAM_BYTES; i++) img[i].data = 8'($random(seed));
    endtask

    // Byte per cycle through the pins, then one strobe after done
    task automatic load_program();
        @(posedge clk);
        uio_in <= 8'h01;
        for (int i = 0; i < RAM_BYTES; i++) begin
            @(posedge clk);
            ui_in  <= img[i].data;
            uio_in <= 8'h03;
            @(negedge clk);
            check_bit("ready", uio_out[ctrl_pkg::PIN_READY], 1'b1);
            check_bit("done", uio_out[ctrl_pkg::PIN_DONE], 1'b0);
            check_bit("halt", uio_out[ctrl_pkg::PIN_HF], 1'b0);    // Cleared by prog
        end
        @(posedge clk);
        uio_in <= 8'h01;                        // Last byte taken at this edge
        ui_in  <= encode(isa_pkg::OP_HLT, 4'd0);
        @(negedge clk);
        check_bit("done", uio_out[ctrl_pkg::PIN_DONE], 1'b1);
        check_bit("ready", uio_out[ctrl_pkg::PIN_READY], 1'b0);
        @(posedge clk);
        uio_in <= 8'h03;                        // Late strobe, HLT would land at address 0
        @(posedge clk);
        uio_in <= 8'h01;
        @(negedge clk);
        check_bit("done", uio_out[ctrl_pkg::PIN_DONE], 1'b1);
    endtask

    // Drops prog and steps the ISA model in lockstep, five cycles per instruction
    task automatic run_program();
        isa_pkg::ram_word_u w;
        logic [3:0] pc;
        logic [7:0] m;
        logic [8:0] sum;
        int         steps;
        bit         halted_m;
        pc       = 4'd0;
        steps    = 0;
        halted_m = 1'b0;
        @(posedge clk);
        uio_in <= 8'h00;                        // T0 of the first instruction follows
        while (!halted_m && steps < MAX_STEPS) begin
            w  = img[pc];
            pc = pc + 4'd1;
            steps++;
            repeat (3) @(posedge clk);          // T0 to T2
            @(negedge clk);                     // Inside T3
            check_bit("halt", uio_out[ctrl_pkg::PIN_HF], w.instr.opcode == isa_pkg::OP_HLT);
            check_byte("uo_out", uo_out, m_out);
            check_bit("carry", uio_out[ctrl_pkg::PIN_CF], m_carry);
            check_bit("zero", uio_out[ctrl_pkg::PIN_ZF], m_zero);
            if (w.instr.opcode == isa_pkg::OP_HLT) begin
                halted_m = 1'b1;
            end else begin
                m = img[w.instr.operand].data;
                case (w.instr.opcode)
                    isa_pkg::OP_LDA: m_a = m;
                    isa_pkg::OP_STA: img[w.instr.operand].data = m_a;
                    isa_pkg::OP_LDI: m_a = {4'd0, w.instr.operand};
                    isa_pkg::OP_OUT: m_out = m_a;
                    isa_pkg::OP_JMP: pc = w.instr.operand;
                    isa_pkg::OP_JC:  if (m_carry) pc = w.instr.operand;
                    isa_pkg::OP_JZ:  if (m_zero) pc = w.instr.operand;
                    default: ;
                endcase
                @(posedge clk);                 // OUT lands on this edge
                @(negedge clk);
                check_byte("uo_out", uo_out, m_out);
                @(posedge clk);                 // End of T4, flags latch
                if (w.instr.opcode == isa_pkg::OP_ADD) begin
                    sum     = {1'b0, m_a} + {1'b0, m};
                    m_a     = sum[7:0];
                    m_carry = sum[8];
                    m_zero  = (sum[7:0] == 8'd0);
                end else if (w.instr.opcode == isa_pkg::OP_SUB) begin
                    m_carry = (m_a >= m);       // No borrow
                    m_a     = m_a - m;
                    m_zero  = (m_a == 8'd0);
                end
            end
        end
        assert (halted_m) else begin
            $display("Program ran %0d instructions without reaching HLT", MAX_STEPS);
            test_errors++;
        end
    endtask

    task automatic hold_halted(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_byte("uo_out", uo_out, m_out);
            check_bit("halt", uio_out[ctrl_pkg::PIN_HF], 1'b1);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        errors += test_errors;
        $display("Test %0d %s: %s", tests_run, name, (test_errors == 0) ? "ok" : "failed");
        test_errors = 0;
    endtask

    initial begin
        arst_n <= 1'b0;
        ena    <= 1'b1;
        ui_in  <= 8'h00;
        uio_in <= 8'h00;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_byte("uo_out", uo_out, 8'h00);
        check_byte("uio_out", uio_out, 8'h00);  // Ready, done, flags, halt all low
        check_byte("uio_oe", uio_oe, ctrl_pkg::UIO_OE_VALUE);
        finish_test("reset values");

        // LDA/OUT pairs read back the random tail
        fill_random();
        for (int i = 0; i < 5; i++) begin
            img[2 * i]     = encode(isa_pkg::OP_LDA, 4'(11 + i));
            img[2 * i + 1] = encode(isa_pkg::OP_OUT, 4'd0);
        end
        img[10] = encode(isa_pkg::OP_HLT, 4'd0);
        load_program();
        run_program();
        finish_test("load and read back");

        fill_random();                          // Data at 6, 7, 8
        img[0] = encode(isa_pkg::OP_LDA, 4'd6);
        img[1] = encode(isa_pkg::OP_ADD, 4'd7);
        img[2] = encode(isa_pkg::OP_OUT, 4'd0); // Shows 14 cycles after prog drops
        img[3] = encode(isa_pkg::OP_SUB, 4'd8);
        img[4] = encode(isa_pkg::OP_OUT, 4'd0);
        img[5] = encode(isa_pkg::OP_HLT, 4'd0);
        load_program();
        run_program();
        finish_test("add, sub and flags");

        fill_random();
        img[0] = encode(isa_pkg::OP_LDA, 4'd15);
        img[1] = encode(isa_pkg::OP_STA, 4'd14);
        img[2] = encode(isa_pkg::OP_LDI, 4'd0);
        img[3] = encode(isa_pkg::OP_OUT, 4'd0);
        img[4] = encode(isa_pkg::OP_LDA, 4'd14);
        img[5] = encode(isa_pkg::OP_OUT, 4'd0);
        img[6] = encode(isa_pkg::OP_LDI, 4'd9);
        img[7] = encode(isa_pkg::OP_OUT, 4'd0);
        img[8] = encode(isa_pkg::OP_HLT, 4'd0);
        load_program();
        run_program();
        finish_test("store, load and immediate");

        // SUB to zero sets both flags, ADD of one clears them
        fill_random();
        img[0]       = encode(isa_pkg::OP_LDA, 4'd13);
        img[1]       = encode(isa_pkg::OP_SUB, 4'd13);
        img[2]       = encode(isa_pkg::OP_JZ, 4'd4);
        img[3]       = encode(isa_pkg::OP_OUT, 4'd0);
        img[4]       = encode(isa_pkg::OP_JC, 4'd6);
        img[5]       = encode(isa_pkg::OP_HLT, 4'd0);   // Target of wrong jumps
        img[6]       = encode(isa_pkg::OP_ADD, 4'd14);
        img[7]       = encode(isa_pkg::OP_JZ, 4'd5);
        img[8]       = encode(isa_pkg::OP_JC, 4'd5);
        img[9]       = encode(isa_pkg::OP_JMP, 4'd11);
        img[10]      = encode(isa_pkg::OP_OUT, 4'd0);
        img[11]      = encode(isa_pkg::OP_OUT, 4'd0);
        img[12]      = encode(isa_pkg::OP_HLT, 4'd0);
        img[14].data = 8'h01;
        load_program();
        run_program();
        finish_test("jumps");

        fill_random();
        img[0] = encode(isa_pkg::OP_LDA, 4'd5);
        img[1] = encode(isa_pkg::OP_OUT, 4'd0);
        img[2] = encode(isa_pkg::OP_HLT, 4'd0);
        img[3] = encode(isa_pkg::OP_LDI, 4'd3); // Never reached
        img[4] = encode(isa_pkg::OP_OUT, 4'd0);
        load_program();
        run_program();
        hold_halted(50);
        load_program();                         // Halt must drop again
        finish_test("halt and reload");

        prop_fails = u_sap_cpu_top.u_props.fail_count;
        $display("Tests run %0d, failed %0d, check errors %0d, property failures %0d",
                 tests_run, tests_failed, errors, prop_fails);
        if (errors == 0 && tests_failed == 0 && prop_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/sap_cpu_props.sv */
// Status pin properties
`default_nettype none

module sap_cpu_props (
    input wire logic       clk,
    input wire logic       arst_n,
    input wire logic [7:0] uio_in,
    input wire logic [7:0] uio_out,
    input wire logic [7:0] uio_oe
);

    timeunit 1ns;
    timeprecision 1ps;

    logic prog;
    logic done;
    logic halted;
    logic oe_bad;                               // Direction pattern broken
    int   fail_count = 0;                       // Tally of failed properties

    assign prog   = uio_in[ctrl_pkg::PIN_PROG];
    assign done   = uio_out[ctrl_pkg::PIN_DONE];
    assign halted = uio_out[ctrl_pkg::PIN_HF];
    assign oe_bad = (uio_oe != ctrl_pkg::UIO_OE_VALUE);

    // Done holds until the loader window closes
    done_holds: assert property (@(posedge clk) disable iff (!arst_n)
        (done && prog && !oe_bad) |=> (done || !prog))
        else begin
            $error("done dropped while programming");
            fail_count++;
        end

    // Leaving programming mode clears the loader
    done_clears: assert property (@(posedge clk) disable iff (!arst_n) !prog |=> !done)
        else begin
            $error("done still high after programming ended");
            fail_count++;
        end

    // Only a reload clears halt
    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        (halted && !prog) |=> halted)
        else begin
            $error("halt dropped without a reload");
            fail_count++;
        end

endmodule

bind sap_cpu_top sap_cpu_props u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
);

`default_nettype wire

/* rtl/sap_cpu_top.sv */
// Accumulator CPU pin wrapper
`default_nettype none

module sap_cpu_top #(
    parameter int RAM_BYTES = 16
) (
    input  wire logic [7:0] ui_in,      // Program bytes
    output logic      [7:0] uo_out,     // OUT register
    input  wire logic [7:0] uio_in,     // Prog and write strobe
    output logic      [7:0] uio_out,    // Status bits
    output logic      [7:0] uio_oe,
    input  wire logic       ena,
    input  wire logic       clk,
    input  wire logic       arst_n
);

    logic [ctrl_pkg::CW_W-1:0]  cw;
    logic [isa_pkg::ADDR_W-1:0] load_addr;
    logic [isa_pkg::OPC_W-1:0]  opcode;
    logic                       carry;
    logic                       zero;
    logic                       ready;
    logic                       done;
    logic                       halted;
    logic                       unused_ok;

    // Status pins, spare bits low
    always_comb begin
        uio_out                     = '0;
        uio_out[ctrl_pkg::PIN_READY] = ready;
        uio_out[ctrl_pkg::PIN_DONE]  = done;
        uio_out[ctrl_pkg::PIN_CF]    = carry;
        uio_out[ctrl_pkg::PIN_ZF]    = zero;
        uio_out[ctrl_pkg::PIN_HF]    = halted;
    end

    assign uio_oe    = ctrl_pkg::UIO_OE_VALUE;
    assign unused_ok = &{ena, uio_in[7:2]};   // Not needed by the design

    control_sequencer #(
        .RAM_BYTES (RAM_BYTES)
    ) u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog      (uio_in[ctrl_pkg::PIN_PROG]),
        .wr        (uio_in[ctrl_pkg::PIN_WR]),
        .opcode    (opcode),
        .carry     (carry),
        .zero      (zero),
        .cw        (cw),
        .load_addr (load_addr),
        .ready     (ready),
        .done      (done),
        .halted    (halted)
    );

    cpu_datapath #(
        .RAM_BYTES (RAM_BYTES)
    ) u_dp (
        .clk       (clk),
        .arst_n    (arst_n),
        .cw        (cw),
        .load_addr (load_addr),
        .ui_in     (ui_in),
        .opcode    (opcode),
        .carry     (carry),
        .zero      (zero),
        .out_value (uo_out)
    );

endmodule

`default_nettype wire

/* rtl/cpu_datapath.sv */
// CPU registers and internal bus
`default_nettype none

module cpu_datapath #(
    parameter int RAM_BYTES = 16
) (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic [ctrl_pkg::CW_W-1:0]  cw,
    input  wire logic [isa_pkg::ADDR_W-1:0] load_addr,
    input  wire logic [isa_pkg::DATA_W-1:0] ui_in,      // Loader byte
    output logic      [isa_pkg::OPC_W-1:0]  opcode,
    output logic                            carry,
    output logic                            zero,
    output logic      [isa_pkg::DATA_W-1:0] out_value
);

    logic [isa_pkg::ADDR_W-1:0] pc;
    logic [isa_pkg::ADDR_W-1:0] mar;
    isa_pkg::ram_word_u         ir;
    logic [isa_pkg::DATA_W-1:0] a_reg;
    logic [isa_pkg::DATA_W-1:0] b_reg;
    logic [isa_pkg::DATA_W-1:0] bus;
    logic [isa_pkg::DATA_W-1:0] alu_result;
    logic [isa_pkg::ADDR_W-1:0] ram_addr;
    logic [isa_pkg::DATA_W-1:0] ram_wdata;
    logic [isa_pkg::DATA_W-1:0] ram_rdata;
    isa_pkg::ram_word_u         rd_word;    // RAM output seen as a word

    assign rd_word = isa_pkg::ram_word_u'(ram_rdata);
    assign opcode  = ir.instr.opcode;

    // Loader takes over the RAM port
    assign ram_addr  = cw[ctrl_pkg::CW_PRG] ? load_addr : mar;
    assign ram_wdata = cw[ctrl_pkg::CW_PRG] ? ui_in : a_reg;

    // One-hot AND-OR bus, zero when nothing drives it
    always_comb begin
        bus = '0;
        if (cw[ctrl_pkg::CW_EP])  bus |= {{(isa_pkg::DATA_W - isa_pkg::ADDR_W){1'b0}}, pc};
        if (cw[ctrl_pkg::CW_CE])  bus |= rd_word.data;
        if (cw[ctrl_pkg::CW_EI]) begin
            bus |= {{(isa_pkg::DATA_W - isa_pkg::ADDR_W){1'b0}}, ir.instr.operand};
        end
        if (cw[ctrl_pkg::CW_EA])  bus |= a_reg;
        if (cw[ctrl_pkg::CW_EU])  bus |= alu_result;
        if (cw[ctrl_pkg::CW_PRG]) bus |= ui_in;         // Input pins during loading
    end

    // PC returns to 0 while loading so the program starts at address 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (cw[ctrl_pkg::CW_PRG]) begin
            pc <= '0;
        end else if (cw[ctrl_pkg::CW_LP]) begin
            pc <= bus[isa_pkg::ADDR_W-1:0];             // Jump target
        end else if (cw[ctrl_pkg::CW_CP]) begin
            pc <= pc + isa_pkg::ADDR_W'(1);
        end
    end

    // MAR, IR and output register, reset so the CPU idles on NOP
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar       <= '0;
            ir        <= '0;
            out_value <= '0;
        end else begin
            if (cw[ctrl_pkg::CW_LMA]) mar <= bus[isa_pkg::ADDR_W-1:0];
            if (cw[ctrl_pkg::CW_LI])  ir <= isa_pkg::ram_word_u'(bus);
            if (cw[ctrl_pkg::CW_LO])  out_value <= bus;   // OUT at T3
        end
    end

    // Accumulator and B operand
    always_ff @(posedge clk) begin
        if (cw[ctrl_pkg::CW_LA]) a_reg <= bus;
        if (cw[ctrl_pkg::CW_LB]) b_reg <= bus;
    end

    alu u_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .a      (a_reg),
        .b      (b_reg),
        .sub    (cw[ctrl_pkg::CW_SUB]),
        .latch  (cw[ctrl_pkg::CW_LF]),
        .result (alu_result),
        .carry  (carry),
        .zero   (zero)
    );

    program_ram #(
        .RAM_BYTES (RAM_BYTES)
    ) u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (cw[ctrl_pkg::CW_WR]),
        .rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* rtl/control_sequencer.sv */
// Control sequencer and program loader
`default_nettype none

module control_sequencer #(
    parameter int RAM_BYTES = 16
) (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic                       prog,       // Loader mode level
    input  wire logic                       wr,         // Loader byte strobe
    input  wire logic [isa_pkg::OPC_W-1:0]  opcode,
    input  wire logic                       carry,      // Stored flags from ALU
    input  wire logic                       zero,
    output logic      [ctrl_pkg::CW_W-1:0]  cw,
    output logic      [isa_pkg::ADDR_W-1:0] load_addr,
    output logic                            ready,
    output logic                            done,
    output logic                            halted
);

    localparam int T_W = $clog2(ctrl_pkg::T_STATES);

    // Named T-states
    localparam logic [T_W-1:0] T0 = T_W'(0);
    localparam logic [T_W-1:0] T1 = T_W'(1);
    localparam logic [T_W-1:0] T2 = T_W'(2);
    localparam logic [T_W-1:0] T3 = T_W'(3);
    localparam logic [T_W-1:0] T4 = T_W'(4);
    localparam logic [T_W-1:0] T_LAST = T_W'(ctrl_pkg::T_STATES - 1);

    logic [T_W-1:0] tstate;
    logic           accept;     // Strobe taken by the loader
    logic           halt_now;   // HLT reaches T2

    assign ready    = prog & ~done;
    assign accept   = ready & wr;
    assign halt_now = (tstate == T2) && (opcode == isa_pkg::OP_HLT) && !halted;

    // T-state ring, cleared while loading, frozen once halted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tstate <= T0;
        end else if (prog) begin
            tstate <= T0;
        end else if (halted || halt_now) begin
            tstate <= tstate;           // Parked at T2
        end else if (tstate == T_LAST) begin
            tstate <= T0;
        end else begin
            tstate <= tstate + T_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (prog) begin
            halted <= 1'b0;             // Reload restarts the CPU
        end else if (halt_now) begin
            halted <= 1'b1;
        end
    end

    // Loader address counter and done flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_addr <= '0;
            done      <= 1'b0;
        end else if (!prog) begin
            load_addr <= '0;
            done      <= 1'b0;
        end else if (accept) begin
            load_addr <= load_addr + isa_pkg::ADDR_W'(1);
            // Last byte closes the window
            if (load_addr == isa_pkg::ADDR_W'(RAM_BYTES - 1)) begin
                done <= 1'b1;
            end
        end
    end

    // Opcode and T-state decode into the control word
    always_comb begin
        cw = '0;
        if (prog) begin
            cw[ctrl_pkg::CW_PRG] = 1'b1;
            cw[ctrl_pkg::CW_WR]  = accept;
        end else if (!halted) begin
            case (tstate)
                T0: begin                               // MAR <= PC
                    cw[ctrl_pkg::CW_EP]  = 1'b1;
                    cw[ctrl_pkg::CW_LMA] = 1'b1;
                end
                T1: begin                               // Fetch, PC++
                    cw[ctrl_pkg::CW_CE] = 1'b1;
                    cw[ctrl_pkg::CW_LI] = 1'b1;
                    cw[ctrl_pkg::CW_CP] = 1'b1;
                end
                T2: begin                               // MAR <= operand
                    cw[ctrl_pkg::CW_EI]  = 1'b1;
                    cw[ctrl_pkg::CW_LMA] = 1'b1;
                end
                T3: begin
                    case (opcode)
                        isa_pkg::OP_LDA: begin
                            cw[ctrl_pkg::CW_CE] = 1'b1;
                            cw[ctrl_pkg::CW_LA] = 1'b1;
                        end
                        isa_pkg::OP_ADD, isa_pkg::OP_SUB: begin
                            cw[ctrl_pkg::CW_CE] = 1'b1;   // Operand into B
                            cw[ctrl_pkg::CW_LB] = 1'b1;
                        end
                        isa_pkg::OP_STA: cw[ctrl_pkg::CW_WR] = 1'b1;
                        isa_pkg::OP_LDI: begin
                            cw[ctrl_pkg::CW_EI] = 1'b1;
                            cw[ctrl_pkg::CW_LA] = 1'b1;
                        end
                        isa_pkg::OP_OUT: begin
                            cw[ctrl_pkg::CW_EA] = 1'b1;
                            cw[ctrl_pkg::CW_LO] = 1'b1;
                        end
                        isa_pkg::OP_JMP: begin
                            cw[ctrl_pkg::CW_EI] = 1'b1;
                            cw[ctrl_pkg::CW_LP] = 1'b1;
                        end
                        isa_pkg::OP_JC: begin
                            cw[ctrl_pkg::CW_EI] = carry;
                            cw[ctrl_pkg::CW_LP] = carry;
                        end
                        isa_pkg::OP_JZ: begin
                            cw[ctrl_pkg::CW_EI] = zero;
                            cw[ctrl_pkg::CW_LP] = zero;
                        end
                        default: cw = '0;               // NOP and spare codes
                    endcase
                end
                T4: begin
                    // ALU result back into A, flags latched
                    if (opcode == isa_pkg::OP_ADD || opcode == isa_pkg::OP_SUB) begin
                        cw[ctrl_pkg::CW_EU]  = 1'b1;
                        cw[ctrl_pkg::CW_LA]  = 1'b1;
                        cw[ctrl_pkg::CW_LF]  = 1'b1;
                        cw[ctrl_pkg::CW_SUB] = (opcode == isa_pkg::OP_SUB);
                    end
                end
                default: cw = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/program_ram.sv */
// Program and data RAM
`default_nettype none

module program_ram #(
    parameter int RAM_BYTES = 16
) (
    input  wire logic                       clk,
    input  wire logic [isa_pkg::ADDR_W-1:0] addr,
    input  wire logic [isa_pkg::DATA_W-1:0] wdata,
    input  wire logic                       we,
    output logic      [isa_pkg::DATA_W-1:0] rdata
);

    logic [isa_pkg::DATA_W-1:0] mem [RAM_BYTES];    // Flop array, contents undefined at power up

    // Single write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Asynchronous read, feeds bus and IR in the same cycle
    assign rdata = mem[addr];

endmodule

`default_nettype wire

/* rtl/alu.sv */
// Adder and subtractor with flags
`default_nettype none

module alu (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire logic [isa_pkg::DATA_W-1:0] a,
    input  wire logic [isa_pkg::DATA_W-1:0] b,
    input  wire logic                       sub,        // 1 gives a - b
    input  wire logic                       latch,      // Store carry and zero
    output logic      [isa_pkg::DATA_W-1:0] result,
    output logic                            carry,
    output logic                            zero
);

    logic [isa_pkg::DATA_W-1:0] b_eff;      // b or its complement
    logic [isa_pkg::DATA_W:0]   sum;        // Extra bit is carry out

    assign b_eff  = sub ? ~b : b;
    // Two's complement subtract, the +1 rides in as carry in
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{isa_pkg::DATA_W{1'b0}}, sub};
    assign result = sum[isa_pkg::DATA_W-1:0];

    // Flags only move on an arithmetic write back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (latch) begin
            carry <= sum[isa_pkg::DATA_W];  // No borrow when subtracting
            zero  <= (result == '0);
        end
    end

endmodule

`default_nettype wire

/* rtl/ctrl_pkg.sv */
// Control word and pin map
`default_nettype none

package ctrl_pkg;

    localparam int CW_W = 16;

    // Control word bits, all active high
    localparam int CW_CP  = 0;      // PC count
    localparam int CW_EP  = 1;      // PC onto bus
    localparam int CW_LP  = 2;      // PC load from bus
    localparam int CW_LMA = 3;      // MAR load from bus
    localparam int CW_CE  = 4;      // RAM onto bus
    localparam int CW_WR  = 5;      // RAM write
    localparam int CW_LI  = 6;      // IR load
    localparam int CW_EI  = 7;      // IR operand onto bus
    localparam int CW_LA  = 8;      // A load
    localparam int CW_EA  = 9;      // A onto bus
    localparam int CW_SUB = 10;     // ALU subtracts
    localparam int CW_EU  = 11;     // ALU onto bus
    localparam int CW_LB  = 12;     // B load
    localparam int CW_LO  = 13;     // Output register load
    localparam int CW_LF  = 14;     // Latch carry and zero
    localparam int CW_PRG = 15;     // Loader owns RAM and bus

    localparam int T_STATES = 5;    // Fixed instruction length

    // Bidirectional pin positions
    localparam int PIN_PROG  = 0;   // uio_in
    localparam int PIN_WR    = 1;   // uio_in
    localparam int PIN_READY = 1;   // uio_out
    localparam int PIN_DONE  = 2;
    localparam int PIN_CF    = 3;
    localparam int PIN_ZF    = 4;
    localparam int PIN_HF    = 5;

    localparam logic [7:0] UIO_OE_VALUE = 8'h3E;  // Bits 1 to 5 are outputs

endpackage

`default_nettype wire

/* rtl/isa_pkg.sv */
// Accumulator CPU instruction set
`default_nettype none

package isa_pkg;

    // Datapath sizes
    localparam int DATA_W = 8;              // Bus, A, B, RAM word
    localparam int ADDR_W = 4;              // PC, MAR, operand field
    localparam int OPC_W  = 4;              // Opcode field

    // Opcodes, high nibble of an instruction byte
    localparam logic [OPC_W-1:0] OP_NOP = 4'd0;
    localparam logic [OPC_W-1:0] OP_LDA = 4'd1;   // A <= RAM[op]
    localparam logic [OPC_W-1:0] OP_ADD = 4'd2;   // A <= A + RAM[op]
    localparam logic [OPC_W-1:0] OP_SUB = 4'd3;   // A <= A - RAM[op]
    localparam logic [OPC_W-1:0] OP_STA = 4'd4;   // RAM[op] <= A
    localparam logic [OPC_W-1:0] OP_LDI = 4'd5;   // A <= op
    localparam logic [OPC_W-1:0] OP_JMP = 4'd6;
    localparam logic [OPC_W-1:0] OP_JC  = 4'd7;   // Jump on stored carry
    localparam logic [OPC_W-1:0] OP_JZ  = 4'd8;   // Jump on stored zero
    localparam logic [OPC_W-1:0] OP_OUT = 4'd14;  // Output register <= A
    localparam logic [OPC_W-1:0] OP_HLT = 4'd15;

    // One RAM word, read as an instruction or as plain data
    typedef union packed {
        struct packed {
            logic [OPC_W-1:0]  opcode;      // High nibble
            logic [ADDR_W-1:0] operand;     // Low nibble, address or immediate
        } instr;
        logic [DATA_W-1:0] data;
    } ram_word_u;

endpackage

`default_nettype wire
